/* source/bar_ctrl_pkg.sv */
package bar_ctrl_pkg;

    // ----------------------------------------------------------------------
    // Data path widths
    // ----------------------------------------------------------------------
    localparam int DW_W       = 32;   // One dword
    localparam int TLP_W      = 128;  // One stream beat
    localparam int BAR_COUNT  = 7;    // Width of the hit vector
    localparam int BAR_IDX_W  = 3;
    localparam int MEM_ADDR_W = 8;    // 256 dwords, 1 KB for BAR0

    // Read context is requester id, tag and lower address (16 + 8 + 7)
    localparam int RD_CTX_W = 31;

    // BARs that actually answer
    localparam logic [BAR_IDX_W-1:0] BAR_MEM_IDX  = BAR_IDX_W'(0);
    localparam logic [BAR_IDX_W-1:0] BAR_LOOP_IDX = BAR_IDX_W'(1);

    // ----------------------------------------------------------------------
    // TLP header codes
    // ----------------------------------------------------------------------
    localparam logic [7:0] FMT_TYPE_MRD32 = 8'h00;  // 3DW memory read
    localparam logic [7:0] FMT_TYPE_MWR32 = 8'h40;  // 3DW memory write with data

    // CplD, length 1
    localparam logic [DW_W-1:0] CPL_DW0        = 32'h4A00_0001;
    localparam logic [11:0]     CPL_BYTE_COUNT = 12'd4;

    // ----------------------------------------------------------------------
    // Completion queue
    // ----------------------------------------------------------------------
    localparam int CPL_QUEUE_DEPTH = 8;
    localparam int CPL_QUEUE_PTR_W = $clog2(CPL_QUEUE_DEPTH);

    // Covers the reads that may still be in flight behind the queue
    localparam int CPL_QUEUE_SLACK = 4;

    // Opcode kind of one request beat
    typedef enum logic [1:0] {
        TLP_NONE,
        TLP_MEM_RD,
        TLP_MEM_WR
    } tlp_kind_e;

    // Wire order of a payload dword is the reverse of register order
    function automatic logic [DW_W-1:0] byte_swap(input logic [DW_W-1:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

endpackage

/* source/tlp_rx_decoder.sv */
`timescale 1ns/1ps

module tlp_rx_decoder
    import bar_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [TLP_W-1:0]      i_tdata,
    input  logic                  i_tvalid,
    input  logic                  i_tfirst,
    input  logic                  i_tlast,
    input  logic [BAR_COUNT-1:0]  i_bar_hit,
    input  logic                  i_bar_en,
    output logic                  o_wr_valid,
    output logic [BAR_IDX_W-1:0]  o_wr_bar,
    output logic [MEM_ADDR_W-1:0] o_wr_addr,
    output logic [3:0]            o_wr_be,
    output logic [DW_W-1:0]       o_wr_data,
    output logic                  o_rd_valid,
    output logic [BAR_IDX_W-1:0]  o_rd_bar,
    output logic [DW_W-1:0]       o_rd_addr,
    output logic [RD_CTX_W-1:0]   o_rd_ctx
);

    logic [7:0]           fmt_type;
    logic [9:0]           length;
    logic                 single_dw;
    logic [BAR_IDX_W-1:0] bar_idx;
    tlp_kind_e            rx_kind;

    assign fmt_type  = i_tdata[31:24];
    assign length    = i_tdata[9:0];
    assign single_dw = i_tfirst && i_tlast && (length == 10'd1);

    // Lowest set bit wins
    always_comb begin
        bar_idx = '0;
        for (int i = BAR_COUNT - 1; i >= 0; i--) begin
            if (i_bar_hit[i]) begin
                bar_idx = BAR_IDX_W'(i);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Beat classification
    // ----------------------------------------------------------------------
    always_comb begin
        rx_kind = TLP_NONE;
        if (i_tvalid && single_dw && i_bar_en && (|i_bar_hit)) begin
            case (fmt_type)
                FMT_TYPE_MRD32: rx_kind = TLP_MEM_RD;
                FMT_TYPE_MWR32: rx_kind = TLP_MEM_WR;
                default:        rx_kind = TLP_NONE;  // 4DW and others dropped
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wr_valid <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            o_wr_valid <= (rx_kind == TLP_MEM_WR);
            o_rd_valid <= (rx_kind == TLP_MEM_RD);
        end
    end

    // Payload fields, sampled every beat
    always_ff @(posedge clk) begin
        o_wr_bar  <= bar_idx;
        o_wr_addr <= i_tdata[66 +: MEM_ADDR_W];          // Dword index
        o_wr_be   <= i_tdata[35:32];
        o_wr_data <= byte_swap(i_tdata[127:96]);
        o_rd_bar  <= bar_idx;
        o_rd_addr <= {i_tdata[95:66], 2'b00};
        // Requester id, tag, lower address
        o_rd_ctx  <= {i_tdata[63:48], i_tdata[47:40], i_tdata[70:66], 2'b00};
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_wr_valid && o_rd_valid));

endmodule

/* source/bar_space.sv */
`timescale 1ns/1ps

module bar_space
    import bar_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_wr_valid,
    input  logic [BAR_IDX_W-1:0]  i_wr_bar,
    input  logic [MEM_ADDR_W-1:0] i_wr_addr,
    input  logic [3:0]            i_wr_be,
    input  logic [DW_W-1:0]       i_wr_data,
    input  logic                  i_rd_valid,
    input  logic [BAR_IDX_W-1:0]  i_rd_bar,
    input  logic [DW_W-1:0]       i_rd_addr,
    input  logic [RD_CTX_W-1:0]   i_rd_ctx,
    output logic                  o_rsp_valid,
    output logic [DW_W-1:0]       o_rsp_data,
    output logic [RD_CTX_W-1:0]   o_rsp_ctx
);

    // ----------------------------------------------------------------------
    // BAR0 storage
    // ----------------------------------------------------------------------
    logic [DW_W-1:0] mem [2**MEM_ADDR_W];

    logic [MEM_ADDR_W-1:0] rd_idx;

    // Read pipeline, stage 1
    logic                 s1_valid;
    logic [BAR_IDX_W-1:0] s1_bar;
    logic [DW_W-1:0]      s1_addr;
    logic [RD_CTX_W-1:0]  s1_ctx;
    logic [DW_W-1:0]      s1_mem_q;

    assign rd_idx = i_rd_addr[MEM_ADDR_W+1:2];

    // BAR0 powers up cleared
    initial begin
        for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_valid && (i_wr_bar == BAR_MEM_IDX)) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr_be[b]) begin
                    mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Two-stage read, shared by BAR0 and BAR1
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            o_rsp_valid <= 1'b0;
        end else begin
            s1_valid    <= i_rd_valid;
            // Other BARs fall out here without a response
            o_rsp_valid <= s1_valid && ((s1_bar == BAR_MEM_IDX) || (s1_bar == BAR_LOOP_IDX));
        end
    end

    always_ff @(posedge clk) begin
        s1_bar  <= i_rd_bar;
        s1_addr <= i_rd_addr;
        s1_ctx  <= i_rd_ctx;
        if (i_rd_valid) begin
            s1_mem_q <= mem[rd_idx];
        end
        o_rsp_data <= (s1_bar == BAR_MEM_IDX) ? s1_mem_q : s1_addr;  // Loopback
        o_rsp_ctx  <= s1_ctx;
    end

    // BAR0 reads stay inside the 1 KB window
    a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
        (i_rd_valid && (i_rd_bar == BAR_MEM_IDX)) |-> (i_rd_addr[DW_W-1:MEM_ADDR_W+2] == '0));

endmodule

/* source/cpl_builder.sv */
`timescale 1ns/1ps

module cpl_builder
    import bar_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         i_pcie_id,
    input  logic                i_rsp_valid,
    input  logic [DW_W-1:0]     i_rsp_data,
    input  logic [RD_CTX_W-1:0] i_rsp_ctx,
    input  logic                i_tready,
    output logic [TLP_W-1:0]    o_tdata,
    output logic                o_tvalid,
    output logic                o_rx_ready
);

    // ----------------------------------------------------------------------
    // Completion beat assembly
    // ----------------------------------------------------------------------
    logic [DW_W-1:0]  cpl_dw1;
    logic [DW_W-1:0]  cpl_dw2;
    logic [TLP_W-1:0] cpl_beat;

    // Completer id bytes go out swapped
    assign cpl_dw1 = {i_pcie_id[7:0], i_pcie_id[15:8], 4'b0000, CPL_BYTE_COUNT};
    // Requester id and tag, then a reserved zero and the lower address
    assign cpl_dw2 = {i_rsp_ctx[30:7], 1'b0, i_rsp_ctx[6:0]};

    assign cpl_beat = {byte_swap(i_rsp_data), cpl_dw2, cpl_dw1, CPL_DW0};

    // ----------------------------------------------------------------------
    // Circular queue
    // ----------------------------------------------------------------------
    logic [TLP_W-1:0]         queue [CPL_QUEUE_DEPTH];
    logic [CPL_QUEUE_PTR_W-1:0] wr_ptr;
    logic [CPL_QUEUE_PTR_W-1:0] rd_ptr;
    logic [CPL_QUEUE_PTR_W:0]   count;
    logic                     push;
    logic                     pop;

    assign push = i_rsp_valid;
    assign pop  = o_tvalid && i_tready;

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= cpl_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue, held until it is taken
    assign o_tvalid = (count != '0);
    assign o_tdata  = queue[rd_ptr];

    // Room for every read still in the pipeline
    assign o_rx_ready = (CPL_QUEUE_DEPTH - int'(count)) >= CPL_QUEUE_SLACK;

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        i_rsp_valid |-> (int'(count) < CPL_QUEUE_DEPTH));

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata)));

endmodule

/* source/bar_ctrl_top.sv */
`timescale 1ns/1ps

module bar_ctrl_top
    import bar_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [TLP_W-1:0]     i_tdata,
    input  logic                 i_tvalid,
    input  logic                 i_tfirst,
    input  logic                 i_tlast,
    input  logic [BAR_COUNT-1:0] i_bar_hit,
    input  logic                 i_bar_en,
    input  logic [15:0]          i_pcie_id,
    input  logic                 i_tready,
    output logic [TLP_W-1:0]     o_tdata,
    output logic                 o_tvalid,
    output logic                 o_rx_ready
);

    // Decoder to BAR space
    logic                  wr_valid;
    logic [BAR_IDX_W-1:0]  wr_bar;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [3:0]            wr_be;
    logic [DW_W-1:0]       wr_data;
    logic                  rd_valid;
    logic [BAR_IDX_W-1:0]  rd_bar;
    logic [DW_W-1:0]       rd_addr;
    logic [RD_CTX_W-1:0]   rd_ctx;

    // BAR space to completion builder
    logic                  rsp_valid;
    logic [DW_W-1:0]       rsp_data;
    logic [RD_CTX_W-1:0]   rsp_ctx;

    tlp_rx_decoder i_tlp_rx_decoder (
        .clk        (clk),
        .rst        (rst),
        .i_tdata    (i_tdata),
        .i_tvalid   (i_tvalid),
        .i_tfirst   (i_tfirst),
        .i_tlast    (i_tlast),
        .i_bar_hit  (i_bar_hit),
        .i_bar_en   (i_bar_en),
        .o_wr_valid (wr_valid),
        .o_wr_bar   (wr_bar),
        .o_wr_addr  (wr_addr),
        .o_wr_be    (wr_be),
        .o_wr_data  (wr_data),
        .o_rd_valid (rd_valid),
        .o_rd_bar   (rd_bar),
        .o_rd_addr  (rd_addr),
        .o_rd_ctx   (rd_ctx)
    );

    bar_space i_bar_space (
        .clk         (clk),
        .rst         (rst),
        .i_wr_valid  (wr_valid),
        .i_wr_bar    (wr_bar),
        .i_wr_addr   (wr_addr),
        .i_wr_be     (wr_be),
        .i_wr_data   (wr_data),
        .i_rd_valid  (rd_valid),
        .i_rd_bar    (rd_bar),
        .i_rd_addr   (rd_addr),
        .i_rd_ctx    (rd_ctx),
        .o_rsp_valid (rsp_valid),
        .o_rsp_data  (rsp_data),
        .o_rsp_ctx   (rsp_ctx)
    );

    cpl_builder i_cpl_builder (
        .clk         (clk),
        .rst         (rst),
        .i_pcie_id   (i_pcie_id),
        .i_rsp_valid (rsp_valid),
        .i_rsp_data  (rsp_data),
        .i_rsp_ctx   (rsp_ctx),
        .i_tready    (i_tready),
        .o_tdata     (o_tdata),
        .o_tvalid    (o_tvalid),
        .o_rx_ready  (o_rx_ready)
    );

    // Requests only arrive while the completion queue has room for them
    a_rx_flow: assert property (@(posedge clk) disable iff (rst)
        (i_tlp_rx_decoder.rx_kind != TLP_NONE) |-> o_rx_ready);

endmodule

/* verif/bar_ctrl_tb.sv */
`timescale 1ns/1ps

module bar_ctrl_tb;

    localparam int          FIELDS      = 13;     // Words per case line
    localparam int          MAX_CASES   = 64;
    localparam int          QUEUE_DEPTH = 8;      // Completion queue entries
    localparam int          QUEUE_SLACK = 4;      // Free entries needed to take a request
    localparam logic [15:0] PCIE_ID     = 16'h0A12;

    logic         clk;
    logic         rst;
    logic [127:0] i_tdata;
    logic         i_tvalid;
    logic         i_tfirst;
    logic         i_tlast;
    logic [6:0]   i_bar_hit;
    logic         i_bar_en;
    logic [15:0]  i_pcie_id;
    logic         i_tready;
    logic [127:0] o_tdata;
    logic         o_tvalid;
    logic         o_rx_ready;

    logic [31:0]  case_words [FIELDS*MAX_CASES];
    logic [127:0] exp_q [$];                      // Completions still owed, in order
    int           num_cases;
    int           exp_total   = 0;
    int           cpl_seen    = 0;
    int           checks      = 0;
    int           errors      = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;
    logic         stall_hold  = 1'b0;
    logic [127:0] stall_data;
    logic         beat_cpl    = 1'b0;             // Driven beat owes a completion
    logic         take_next   = 1'b0;             // Head leaves on the next rising edge
    logic [2:0]   cpl_pipe    = '0;
    int           queued      = 0;                // Entries the queue should hold

    bar_ctrl_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_tdata    (i_tdata),
        .i_tvalid   (i_tvalid),
        .i_tfirst   (i_tfirst),
        .i_tlast    (i_tlast),
        .i_bar_hit  (i_bar_hit),
        .i_bar_en   (i_bar_en),
        .i_pcie_id  (i_pcie_id),
        .i_tready   (i_tready),
        .o_tdata    (o_tdata),
        .o_tvalid   (o_tvalid),
        .o_rx_ready (o_rx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Case table access and beat construction
    // ----------------------------------------------------------------------
    function automatic logic [31:0] case_field(input int c, input int f);
        return case_words[c*FIELDS + f];
    endfunction

    function automatic logic [127:0] request_beat(input int c);
        logic [31:0] fmt;
        logic [31:0] len;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] tag;
        logic [31:0] rid;
        logic [31:0] wdata;
        fmt   = case_field(c, 0);
        len   = case_field(c, 3);
        addr  = case_field(c, 6);
        be    = case_field(c, 7);
        tag   = case_field(c, 8);
        rid   = case_field(c, 9);
        wdata = case_field(c, 10);
        return {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24],  // Payload on the wire
                addr[31:2], 2'b00,
                rid[15:0], tag[7:0], 4'h0, be[3:0],
                fmt[7:0], 14'h0, len[9:0]};
    endfunction

    // CplD as seen on the output stream
    function automatic logic [127:0] expected_cpl(input int c);
        logic [31:0] addr;
        logic [31:0] tag;
        logic [31:0] rid;
        logic [31:0] data;
        addr = case_field(c, 6);
        tag  = case_field(c, 8);
        rid  = case_field(c, 9);
        data = case_field(c, 12);
        return {data[7:0], data[15:8], data[23:16], data[31:24],
                rid[15:0], tag[7:0], 1'b0, addr[6:2], 2'b00,
                PCIE_ID[7:0], PCIE_ID[15:8], 4'h0, 12'd4,
                32'h4A00_0001};
    endfunction

    task automatic load_cases();
        for (int i = 0; i < FIELDS*MAX_CASES; i++) begin
            case_words[i] = 32'hFFFF_FFFF;  // End marker
        end
        $readmemh("verif/bar_ctrl_cases.txt", case_words);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_words[num_cases*FIELDS] !== 32'hFFFF_FFFF) begin
            num_cases++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Driver
    // ----------------------------------------------------------------------
    task automatic drive_case(input int c);
        logic [31:0] hit;
        while (!o_rx_ready) @(negedge clk);
        hit       = case_field(c, 4);
        i_tdata   = request_beat(c);
        i_tfirst  = case_field(c, 1) != 0;
        i_tlast   = case_field(c, 2) != 0;
        i_bar_hit = hit[6:0];
        i_bar_en  = case_field(c, 5) != 0;
        beat_cpl  = case_field(c, 11) != 0;
        i_tvalid  = 1'b1;
        if (case_field(c, 11) != 0) begin
            exp_q.push_back(expected_cpl(c));
            exp_total++;
        end
        @(negedge clk);
        i_tvalid  = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Monitor and checks
    // ----------------------------------------------------------------------
    task automatic compare_dword(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_completion();
        logic [127:0] exp_beat;
        cpl_seen++;
        checks++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected completion at %0t ns with no read outstanding", $time);
        end else begin
            exp_beat = exp_q.pop_front();
            compare_dword("o_tdata[31:0]", o_tdata[31:0], exp_beat[31:0]);
            compare_dword("o_tdata[63:32]", o_tdata[63:32], exp_beat[63:32]);
            compare_dword("o_tdata[95:64]", o_tdata[95:64], exp_beat[95:64]);
            compare_dword("o_tdata[127:96]", o_tdata[127:96], exp_beat[127:96]);
        end
    endtask

    task automatic check_stall();
        checks++;
        if (!o_tvalid) begin
            errors++;
            $display("o_tvalid dropped at %0t ns before the stalled beat was taken", $time);
        end else if (o_tdata !== stall_data) begin
            errors++;
            $display("error at %0t ns: o_tdata got %h expected %h", $time, o_tdata, stall_data);
        end
    endtask

    // Ready level and head valid against the modelled occupancy
    task automatic verify_queue_flags();
        logic exp_ready;
        logic exp_valid;
        exp_ready = (QUEUE_DEPTH - queued) >= QUEUE_SLACK;
        exp_valid = queued != 0;
        checks++;
        if (o_rx_ready !== exp_ready) begin
            errors++;
            $display("error at %0t ns: o_rx_ready got %b expected %b", $time, o_rx_ready,
                     exp_ready);
        end
        if (o_tvalid !== exp_valid) begin
            errors++;
            $display("error at %0t ns: o_tvalid got %b expected %b", $time, o_tvalid,
                     exp_valid);
        end
    endtask

    // A read beat lands in the queue on the fourth rising edge after it is taken
    always @(posedge clk) begin
        if (rst) begin
            cpl_pipe = '0;
            queued   = 0;
        end else begin
            if (cpl_pipe[2]) begin
                queued++;
            end
            if (take_next) begin
                queued--;
            end
            cpl_pipe = {cpl_pipe[1:0], i_tvalid && beat_cpl};
        end
    end

    // Random back-pressure; a beat moves on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            verify_queue_flags();
            if (stall_hold) begin
                check_stall();
            end
            i_tready   = ($urandom % 4) != 0;
            stall_hold = o_tvalid && !i_tready;
            stall_data = o_tdata;
            take_next  = o_tvalid && i_tready;
            if (o_tvalid && i_tready) begin
                check_completion();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d completions missing", cycle_count, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    task automatic run_cases();
        for (int c = 0; c < num_cases; c++) begin
            drive_case(c);
        end
        while (exp_q.size() > 0 || o_tvalid) @(negedge clk);
        repeat (20) @(negedge clk);  // Catch late strays
        checks++;
        if (cpl_seen != exp_total) begin
            errors++;
            $display("Saw %0d completions but %0d were expected", cpl_seen, exp_total);
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, completions %0d of %0d", checks, errors, cpl_seen,
                 exp_total);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        int seed_draw;
        rst       = 1'b1;
        i_tdata   = '0;
        i_tvalid  = 1'b0;
        i_tfirst  = 1'b0;
        i_tlast   = 1'b0;
        i_bar_hit = '0;
        i_bar_en  = 1'b0;
        i_pcie_id = PCIE_ID;
        i_tready  = 1'b0;
        seed_draw = $urandom(50);
        load_cases();
        cycle_limit = 40 * num_cases + 200;
        if (num_cases == 0) begin
            $display("No cases could be read from verif/bar_ctrl_cases.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            run_cases();
            finish_run();
        end
    end

endmodule

/* verif/bar_ctrl_cases.txt */
// fmt first last len bar_hit bar_en addr be tag req_id wdata cpl_expected rd_data
// All hex, one request TLP per line; wdata and rd_data in register byte order
00 1 1 001 01 1 00000010 f 01 1100 00000000 1 00000000  // Unwritten dword
40 1 1 001 01 1 00000010 f 02 1100 11223344 0 00000000
00 1 1 001 01 1 00000010 f 03 1100 00000000 1 11223344
40 1 1 001 01 1 00000010 5 04 2201 aabbccdd 0 00000000  // Bytes 0 and 2 only
00 1 1 001 01 1 00000010 f 05 2201 00000000 1 11bb33dd
40 1 1 001 01 1 000003fc f 06 2201 deadbeef 0 00000000  // Top dword of BAR0
00 1 1 001 01 1 000003fc f 07 3302 00000000 1 deadbeef
40 1 1 001 01 1 00000020 8 08 3302 99887766 0 00000000
00 1 1 001 01 1 00000020 f 09 3302 00000000 1 99000000
00 1 1 001 02 1 12345678 f 0a 4403 00000000 1 12345678  // BAR1 loopback
00 1 1 001 02 1 ffff0044 f 0b 4403 00000000 1 ffff0044
00 1 1 001 08 1 00000010 f 0c 4403 00000000 0 00000000  // BAR3, no response
00 1 1 001 01 0 00000010 f 0d 4403 00000000 0 00000000  // Decode disabled
00 1 1 001 04 1 00000010 f 0e 4403 00000000 0 00000000  // BAR2
40 0 1 001 01 1 00000010 f 0f 5504 55555555 0 00000000  // Not first
40 1 0 001 01 1 00000010 f 10 5504 55555555 0 00000000  // Not last
40 1 1 002 01 1 00000010 f 11 5504 55555555 0 00000000  // Length 2
60 1 1 001 01 1 00000010 f 12 5504 55555555 0 00000000  // 4DW write
40 1 1 001 01 0 00000010 f 13 5504 55555555 0 00000000
40 1 1 001 08 1 00000010 f 14 5504 55555555 0 00000000  // Write to BAR3 dropped
00 1 1 001 01 1 00000010 f 15 6605 00000000 1 11bb33dd  // Memory unchanged
00 1 1 001 03 1 00000020 f 16 6605 00000000 1 99000000  // Lowest hit bit wins
20 1 1 001 01 1 00000010 f 17 6605 00000000 0 00000000  // 4DW read
00 1 1 001 01 1 000003fc f 18 7706 00000000 1 deadbeef
00 1 1 001 02 1 00000400 f 19 7706 00000000 1 00000400
00 1 1 001 01 1 00000010 f 1a 7706 00000000 1 11bb33dd
00 1 1 001 01 1 00000040 f 1b 7706 00000000 1 00000000
00 1 1 001 02 1 0000007c f 1c 7706 00000000 1 0000007c

/* bar_ctrl.f */
source/bar_ctrl_pkg.sv
source/tlp_rx_decoder.sv
source/bar_space.sv
source/cpl_builder.sv
source/bar_ctrl_top.sv
verif/bar_ctrl_tb.sv

/* Bender.yml */
package:
  name: bar_ctrl

sources:
  - files:
      - source/bar_ctrl_pkg.sv
      - source/tlp_rx_decoder.sv
      - source/bar_space.sv
      - source/cpl_builder.sv
      - source/bar_ctrl_top.sv
  - target: test
    files:
      - verif/bar_ctrl_tb.sv
